// File: common/fifo_pkg.sv
// shared widths, types and pointer code conversions for the dual-clock FIFO
// imported by every RTL file of the design

package fifo_pkg;

  localparam int DATA_W = 40;
  localparam int ADDR_W = 4;
  localparam int DEPTH  = 16;  // 2**ADDR_W words

  typedef logic [DATA_W-1:0] data_t;   // one FIFO word
  typedef logic [ADDR_W-1:0] addr_t;   // memory address, almost thresholds
  typedef logic [ADDR_W:0]   ptr_t;    // address plus wrap bit
  typedef logic [ADDR_W:0]   level_t;  // fill level 0..DEPTH

  // binary to reflected Gray code
  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  // Gray back to binary, msb first
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_W] = gray[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: common/fifo_mem_if.sv
// memory port of the FIFO, write address from the clk side and
// read address and data on the rd_clk side

`timescale 1ns/1ns

interface fifo_mem_if;
  import fifo_pkg::*;

  logic  wen;    // qualified write strobe, clk domain
  addr_t waddr;
  addr_t raddr;  // rd_clk domain
  data_t rdata;  // word at raddr, no register

  modport wr (
    output wen,
    output waddr
  );

  modport rd (
    output raddr,
    input  rdata
  );

  modport mem (
    input  wen,
    input  waddr,
    input  raddr,
    output rdata
  );

endinterface

// File: async_fifo/fifo_mem.sv
// FIFO storage array, written on clk, read combinationally at raddr
// so the read side sees the oldest word without a cycle of delay

`timescale 1ns/1ns

module fifo_mem (
  input  logic            clk,
  input  fifo_pkg::data_t wr_data,
  fifo_mem_if.mem         mem
);
  import fifo_pkg::*;

  data_t store [DEPTH];

  // wen is already qualified with full by write control
  always_ff @(posedge clk) begin
    if (mem.wen) begin
      store[mem.waddr] <= wr_data;
    end
  end

  assign mem.rdata = store[mem.raddr];  // no read register

endmodule

// File: async_fifo/fifo_wr_ctl.sv
// write side of the FIFO on clk with its pointers, the read pointer sync
// and the full, almost_full and half_full flags

`timescale 1ns/1ns

module fifo_wr_ctl (
  input  logic            clk,
  input  logic            reset,
  input  logic            wr_en,
  input  fifo_pkg::addr_t almost_full_level,
  input  fifo_pkg::ptr_t  rd_gray,
  output fifo_pkg::ptr_t  wr_gray,
  fifo_mem_if.wr          mem,
  output logic            full,
  output logic            almost_full,
  output logic            half_full
);
  import fifo_pkg::*;

  ptr_t   wr_bin;
  ptr_t   wr_bin_next;
  ptr_t   wr_gray_next;
  ptr_t   rd_gray_meta;   // first sync stage
  ptr_t   rd_gray_sync;
  ptr_t   rd_bin_sync;
  level_t level_next;
  logic   wr_accept;

  assign wr_accept    = wr_en & ~full;  // requests while full are dropped
  assign wr_bin_next  = wr_bin + ptr_t'(wr_accept);
  assign wr_gray_next = bin_to_gray(wr_bin_next);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  assign mem.wen   = wr_accept;
  assign mem.waddr = wr_bin[ADDR_W-1:0];

  // two flops for the read pointer coming from rd_clk
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  assign rd_bin_sync = gray_to_bin(rd_gray_sync);

  // fill level after this edge, as seen from the write side
  assign level_next = wr_bin_next - rd_bin_sync;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full        <= 1'b0;
      almost_full <= 1'b0;
      half_full   <= 1'b0;
    end else begin
      // full when the two msbs differ and the rest match
      full        <= (wr_gray_next == {~rd_gray_sync[ADDR_W:ADDR_W-1],
                                       rd_gray_sync[ADDR_W-2:0]});
      almost_full <= (level_next >= {1'b0, almost_full_level});  // stays high when full
      half_full   <= (level_next >= level_t'(DEPTH / 2));
    end
  end

  // a write while full would put the pointer more than DEPTH words ahead
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (reset)
    level_t'(wr_bin - rd_bin_sync) <= level_t'(DEPTH)
  ) else $error("write pointer moved while full");

endmodule

// File: async_fifo/fifo_rd_ctl.sv
// read side of the FIFO on rd_clk with its pointers, write pointer sync and flags
// also passes the oldest word from the memory to rd_data

`timescale 1ns/1ns

module fifo_rd_ctl (
  input  logic            rd_clk,
  input  logic            reset,
  input  logic            rd_en,
  input  fifo_pkg::addr_t almost_empty_level,
  input  fifo_pkg::ptr_t  wr_gray,
  output fifo_pkg::ptr_t  rd_gray,
  fifo_mem_if.rd          mem,
  output fifo_pkg::data_t rd_data,
  output logic            empty,
  output logic            almost_empty
);
  import fifo_pkg::*;

  ptr_t   rd_bin;
  ptr_t   rd_bin_next;
  ptr_t   rd_gray_next;
  ptr_t   wr_gray_meta;
  ptr_t   wr_gray_sync;
  level_t level_next;
  logic   rd_accept;

  assign rd_accept    = rd_en & ~empty;  // pops on empty are ignored
  assign rd_bin_next  = rd_bin + ptr_t'(rd_accept);
  assign rd_gray_next = bin_to_gray(rd_bin_next);

  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  assign mem.raddr = rd_bin[ADDR_W-1:0];
  assign rd_data   = mem.rdata;  // fall-through word

  // write pointer into rd_clk
  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  assign level_next = gray_to_bin(wr_gray_sync) - rd_bin_next;

  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      empty        <= 1'b1;
      almost_empty <= 1'b1;
    end else begin
      empty        <= (rd_gray_next == wr_gray_sync);
      almost_empty <= (level_next <= {1'b0, almost_empty_level});
    end
  end

  // a pop while empty would put the read pointer past the write pointer
  a_no_pop_when_empty : assert property (
    @(posedge rd_clk) disable iff (reset)
    level_t'(gray_to_bin(wr_gray_sync) - rd_bin) <= level_t'(DEPTH)
  ) else $error("read pointer moved while empty");

endmodule

// File: hdl/async_fifo_top.sv
// dual-clock FIFO, 16 words of 40 bits, written on clk and read on rd_clk
// read data is first-word-fall-through, thresholds are set by the ports

`timescale 1ns/1ns

module async_fifo_top (
  input  logic            clk,
  input  logic            rd_clk,
  input  logic            reset,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  input  fifo_pkg::addr_t almost_full_level,
  input  fifo_pkg::addr_t almost_empty_level,
  output logic            full,
  output logic            almost_full,
  output logic            half_full,
  output logic            empty,
  output logic            almost_empty
);
  import fifo_pkg::*;

  ptr_t wr_gray;  // clk domain, synchronized inside read control
  ptr_t rd_gray;  // rd_clk domain, synchronized inside write control

  fifo_mem_if mem_if ();

  fifo_wr_ctl u_wr_ctl (
    .clk               (clk),
    .reset             (reset),
    .wr_en             (wr_en),
    .almost_full_level (almost_full_level),
    .rd_gray           (rd_gray),
    .wr_gray           (wr_gray),
    .mem               (mem_if),
    .full              (full),
    .almost_full       (almost_full),
    .half_full         (half_full)
  );

  fifo_rd_ctl u_rd_ctl (
    .rd_clk             (rd_clk),
    .reset              (reset),
    .rd_en              (rd_en),
    .almost_empty_level (almost_empty_level),
    .wr_gray            (wr_gray),
    .rd_gray            (rd_gray),
    .mem                (mem_if),
    .rd_data            (rd_data),
    .empty              (empty),
    .almost_empty       (almost_empty)
  );

  // only place where both addresses meet
  fifo_mem u_mem (
    .clk     (clk),
    .wr_data (wr_data),
    .mem     (mem_if)
  );

endmodule

// File: sim/tb_async_fifo.sv
// self-checking testbench for the dual-clock FIFO with a queue that models its contents
// compile from the project root with sources.f and tb_async_fifo as top module

`timescale 1ns/1ns

module tb_async_fifo;
  import fifo_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;  // the tests need about 2000 clk cycles

  logic  clk    = 1'b0;
  logic  rd_clk = 1'b0;
  logic  reset;
  logic  wr_en;
  logic  rd_en;
  data_t wr_data;
  data_t rd_data;
  addr_t almost_full_level;
  addr_t almost_empty_level;
  logic  full;
  logic  almost_full;
  logic  half_full;
  logic  empty;
  logic  almost_empty;

  data_t  model [$];  // words accepted and not yet popped
  integer seed;
  int     cycles = 0;
  string  test_name;
  addr_t  af_list [4] = '{4'd12, 4'd4, 4'd15, 4'd0};
  addr_t  ae_list [4] = '{4'd2, 4'd7, 4'd0, 4'd15};
  int     targets [5] = '{0, 3, 8, 12, 16};

  always #4 clk = ~clk;
  always #5.5 rd_clk = ~rd_clk;  // rounds to 6 ns at 1 ns precision

  async_fifo_top async_fifo_top_i (
    .clk                (clk),
    .rd_clk             (rd_clk),
    .reset              (reset),
    .wr_en              (wr_en),
    .wr_data            (wr_data),
    .rd_en              (rd_en),
    .rd_data            (rd_data),
    .almost_full_level  (almost_full_level),
    .almost_empty_level (almost_empty_level),
    .full               (full),
    .almost_full        (almost_full),
    .half_full          (half_full),
    .empty              (empty),
    .almost_empty       (almost_empty)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) fail_run("timeout: the tests did not finish in time");
  end

  // flag order is full, almost_full, half_full, empty, almost_empty
  function automatic logic [4:0] expected_flags(input int count, input addr_t af_level,
                                                input addr_t ae_level);
    logic [4:0] f;
    f[4] = (count == 16);
    f[3] = (count >= int'(af_level));
    f[2] = (count >= 8);
    f[1] = (count == 0);
    f[0] = (count <= int'(ae_level));
    return f;
  endfunction

  function automatic logic [4:0] dut_flags();
    return {full, almost_full, half_full, empty, almost_empty};
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flags(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) fail_run($sformatf("Fail %s: expected flags %b, actual %b", name, exp, act));
  endtask

  function automatic data_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[DATA_W-1:0];
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // one clk cycle of the write side with accepted words going into the model
  task automatic wr_cycle(input logic en, input data_t d);
    @(posedge clk);
    #1;
    wr_en   = en;
    wr_data = d;
    if (en && !full) model.push_back(d);
  endtask

  // one rd_clk cycle that checks rd_data against the model before the pop
  task automatic rd_cycle(input logic en);
    data_t exp;
    @(posedge rd_clk);
    #1;
    rd_en = en;
    if (en && !empty) begin
      if (model.size() == 0) begin
        fail_run("the read side popped a word that was never written");
      end else begin
        exp = model.pop_front();
        check_data(test_name, exp, rd_data);
      end
    end
  endtask

  task automatic settle();
    wr_cycle(1'b0, '0);
    rd_cycle(1'b0);
    repeat (6) @(posedge clk);
    repeat (6) @(posedge rd_clk);
    #1;
  endtask

  task automatic check_level();
    settle();
    check_flags(test_name, expected_flags(model.size(), almost_full_level, almost_empty_level),
                dut_flags());
  endtask

  task automatic drain();
    while (model.size() != 0) rd_cycle(1'b1);
    rd_cycle(1'b0);
  endtask

  task automatic set_levels(input addr_t af_level, input addr_t ae_level);
    @(posedge clk);
    #1 almost_full_level = af_level;
    @(posedge rd_clk);
    #1 almost_empty_level = ae_level;
  endtask

  initial begin
    seed               = 32'he9b5;
    reset              = 1'b1;
    wr_en              = 1'b0;
    rd_en              = 1'b0;
    wr_data            = '0;
    almost_full_level  = 4'd12;
    almost_empty_level = 4'd2;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    test_name = "reset_flags";
    check_level();

    test_name = "fill_full";
    repeat (16) wr_cycle(1'b1, rand_word());
    check_level();
    repeat (4) wr_cycle(1'b1, rand_word());  // dropped while full
    wr_cycle(1'b0, '0);
    if (model.size() != 16) fail_run("writes were accepted while the FIFO was full");
    drain();
    check_level();

    test_name = "read_empty";
    repeat (20) begin
      rd_cycle(1'b1);
      if (empty !== 1'b1) fail_run("empty went low while reading an empty FIFO");
    end
    rd_cycle(1'b0);
    wr_cycle(1'b1, rand_word());
    wr_cycle(1'b0, '0);
    drain();
    check_level();

    for (int i = 0; i < 4; i++) begin
      set_levels(af_list[i], ae_list[i]);
      for (int j = 0; j < 5; j++) begin
        test_name = $sformatf("levels_af%0d_ae%0d_count%0d", af_list[i], ae_list[i], targets[j]);
        while (model.size() < targets[j]) wr_cycle(1'b1, rand_word());
        check_level();
      end
      drain();
    end

    test_name = "streaming";
    set_levels(4'd12, 4'd2);
    fork
      begin
        repeat (500) wr_cycle(rand_bit(), rand_word());
        wr_cycle(1'b0, '0);
      end
      begin
        repeat (500) rd_cycle(rand_bit());
        rd_cycle(1'b0);
      end
    join
    drain();
    check_level();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: sources.f
common/fifo_pkg.sv
common/fifo_mem_if.sv
async_fifo/fifo_mem.sv
async_fifo/fifo_wr_ctl.sv
async_fifo/fifo_rd_ctl.sv
hdl/async_fifo_top.sv
sim/tb_async_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the FIFO testbench with Verilator and runs it, exit status 1 on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  -f sources.f --top-module tb_async_fifo -o tb_async_fifo || exit 1

out="$(./obj_dir/tb_async_fifo)"
echo "$out"

echo "$out" | grep -qx "Result: PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
